//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
SEED      ?= 4115
LOG       ?= sim.log
FILELIST  ?= cpu.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# The run fails if the log holds the fail message
sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -GrandSeed=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cpu.f
hw/isaPkg.sv
hw/pipePkg.sv
hw/fetchStage.sv
hw/regFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memWriteback.sv
hw/hazardUnit.sv
hw/cpu.sv
testbench/isaModel.sv
testbench/cpuTb.sv

//--- hw/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu
    import isaPkg::*;
    import pipePkg::*;
#(
    parameter logic [dataWidth-1:0] resetVector = '0
) (
    input  wire                  clk,
    input  wire                  reset,
    output logic [dataWidth-1:0] instrAddr,
    input  wire  [dataWidth-1:0] instr,
    output logic [dataWidth-1:0] prAddr,
    output logic [dataWidth-1:0] prWriteData,
    output logic                 prWrite,
    input  wire  [dataWidth-1:0] prReadData
);
    // IF/ID
    instrT                   instrD;
    logic [dataWidth-1:0]    pc4D;
    logic                    branchTaken;
    logic [dataWidth-1:0]    branchTarget;

    // Decode
    logic [regAddrWidth-1:0] readAddrA;
    logic [regAddrWidth-1:0] readAddrB;
    logic [dataWidth-1:0]    readDataA;
    logic [dataWidth-1:0]    readDataB;
    logic                    isBranchD;

    // ID/EX
    logic [aluOpWidth-1:0]   aluOpE;
    logic                    aluSrcImmE;
    logic                    regWriteE;
    logic                    memReadE;
    logic                    memWriteE;
    logic [regAddrWidth-1:0] destE;
    logic [regAddrWidth-1:0] srcAE;
    logic [regAddrWidth-1:0] srcBE;
    logic [dataWidth-1:0]    operandAE;
    logic [dataWidth-1:0]    operandBE;
    logic [dataWidth-1:0]    immE;

    // EX/MEM and MEM/WB
    logic [dataWidth-1:0]    aluResultM;
    logic [dataWidth-1:0]    storeDataM;
    logic                    regWriteM;
    logic                    memReadM;
    logic                    memWriteM;
    logic [regAddrWidth-1:0] destM;
    logic                    regWriteW;
    logic [regAddrWidth-1:0] destW;
    logic [dataWidth-1:0]    writeDataW;

    // Hazard control
    logic                    stallFetch;
    logic                    flushExecute;
    logic [fwdWidth-1:0]     fwdSrcAD;
    logic [fwdWidth-1:0]     fwdSrcBD;
    logic [fwdWidth-1:0]     fwdSrcAE;
    logic [fwdWidth-1:0]     fwdSrcBE;

    fetchStage #(
        .resetVector(resetVector)
    ) fetch (
        .clk(clk),
        .reset(reset),
        .stallFetch(stallFetch),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .instr(instr),
        .instrAddr(instrAddr),
        .instrD(instrD),
        .pc4D(pc4D)
    );

    decodeStage decode (
        .clk(clk),
        .reset(reset),
        .instrD(instrD),
        .pc4D(pc4D),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .fwdSrcAD(fwdSrcAD),
        .fwdSrcBD(fwdSrcBD),
        .aluResultM(aluResultM),
        .writeDataW(writeDataW),
        .flushExecute(flushExecute),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .isBranchD(isBranchD),
        .aluOpE(aluOpE),
        .aluSrcImmE(aluSrcImmE),
        .regWriteE(regWriteE),
        .memReadE(memReadE),
        .memWriteE(memWriteE),
        .destE(destE),
        .srcAE(srcAE),
        .srcBE(srcBE),
        .operandAE(operandAE),
        .operandBE(operandBE),
        .immE(immE)
    );

    regFile regs (
        .clk(clk),
        .reset(reset),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .regWriteW(regWriteW),
        .destW(destW),
        .writeDataW(writeDataW),
        .readDataA(readDataA),
        .readDataB(readDataB)
    );

    executeStage execute (
        .clk(clk),
        .reset(reset),
        .aluOpE(aluOpE),
        .aluSrcImmE(aluSrcImmE),
        .regWriteE(regWriteE),
        .memReadE(memReadE),
        .memWriteE(memWriteE),
        .destE(destE),
        .operandAE(operandAE),
        .operandBE(operandBE),
        .immE(immE),
        .fwdSrcAE(fwdSrcAE),
        .fwdSrcBE(fwdSrcBE),
        .writeDataW(writeDataW),
        .aluResultM(aluResultM),
        .storeDataM(storeDataM),
        .regWriteM(regWriteM),
        .memReadM(memReadM),
        .memWriteM(memWriteM),
        .destM(destM)
    );

    memWriteback memWb (
        .clk(clk),
        .reset(reset),
        .aluResultM(aluResultM),
        .storeDataM(storeDataM),
        .regWriteM(regWriteM),
        .memReadM(memReadM),
        .memWriteM(memWriteM),
        .destM(destM),
        .prReadData(prReadData),
        .prAddr(prAddr),
        .prWriteData(prWriteData),
        .prWrite(prWrite),
        .regWriteW(regWriteW),
        .destW(destW),
        .writeDataW(writeDataW)
    );

    hazardUnit hazard (
        .srcAD(readAddrA),
        .srcBD(readAddrB),
        .isBranchD(isBranchD),
        .srcAE(srcAE),
        .srcBE(srcBE),
        .destE(destE),
        .memReadE(memReadE),
        .regWriteE(regWriteE),
        .destM(destM),
        .memReadM(memReadM),
        .regWriteM(regWriteM),
        .destW(destW),
        .regWriteW(regWriteW),
        .stallFetch(stallFetch),
        .flushExecute(flushExecute),
        .fwdSrcAD(fwdSrcAD),
        .fwdSrcBD(fwdSrcBD),
        .fwdSrcAE(fwdSrcAE),
        .fwdSrcBE(fwdSrcBE)
    );

endmodule

`default_nettype wire

//--- hw/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire  instrT              instrD,
    input  wire  [dataWidth-1:0]     pc4D,
    input  wire  [dataWidth-1:0]     readDataA,
    input  wire  [dataWidth-1:0]     readDataB,
    input  wire  [fwdWidth-1:0]      fwdSrcAD,
    input  wire  [fwdWidth-1:0]      fwdSrcBD,
    input  wire  [dataWidth-1:0]     aluResultM,
    input  wire  [dataWidth-1:0]     writeDataW,
    input  wire                      flushExecute,
    output logic [regAddrWidth-1:0]  readAddrA,
    output logic [regAddrWidth-1:0]  readAddrB,
    output logic                     branchTaken,
    output logic [dataWidth-1:0]     branchTarget,
    output logic                     isBranchD,
    output logic [aluOpWidth-1:0]    aluOpE,
    output logic                     aluSrcImmE,
    output logic                     regWriteE,
    output logic                     memReadE,
    output logic                     memWriteE,
    output logic [regAddrWidth-1:0]  destE,
    output logic [regAddrWidth-1:0]  srcAE,
    output logic [regAddrWidth-1:0]  srcBE,
    output logic [dataWidth-1:0]     operandAE,
    output logic [dataWidth-1:0]     operandBE,
    output logic [dataWidth-1:0]     immE
);
    logic [aluOpWidth-1:0]   aluOp;
    logic                    aluSrcImm;
    logic                    regWrite;
    logic                    memRead;
    logic                    memWrite;
    logic                    signExt;
    logic [regAddrWidth-1:0] dest;
    logic [dataWidth-1:0]    immExt;
    logic [dataWidth-1:0]    opA;
    logic [dataWidth-1:0]    opB;

    assign readAddrA = instrD.iType.rs;
    assign readAddrB = instrD.iType.rt;

    always_comb begin
        aluOp     = aluAdd;
        aluSrcImm = 1'b0;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        signExt   = 1'b1;
        isBranchD = 1'b0;
        dest      = '0;
        case (instrD.rType.op)
            opSpecial: begin
                regWrite = 1'b1;
                dest     = instrD.rType.rd;
                case (instrD.rType.funct)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    // Anything else, sll $0 included, retires as a nop
                    default: begin
                        regWrite = 1'b0;
                        dest     = '0;
                    end
                endcase
            end
            opAddiu, opLw: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                memRead   = (instrD.rType.op == opLw);
                dest      = instrD.iType.rt;
            end
            opOri, opLui: begin
                aluOp     = (instrD.rType.op == opLui) ? aluLui : aluOr;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                signExt   = 1'b0;
                dest      = instrD.iType.rt;
            end
            opSw: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            opBeq, opBne: isBranchD = 1'b1;
            default: ;
        endcase
    end

    assign immExt = signExt ? {{16{instrD.iType.imm[15]}}, instrD.iType.imm}
                            : {16'h0000, instrD.iType.imm};

    // Bypassed operands feed both the compare and ID/EX
    assign opA = (fwdSrcAD == fwdMem) ? aluResultM :
                 (fwdSrcAD == fwdWb)  ? writeDataW : readDataA;
    assign opB = (fwdSrcBD == fwdMem) ? aluResultM :
                 (fwdSrcBD == fwdWb)  ? writeDataW : readDataB;

    assign branchTaken  = isBranchD && ((opA == opB) != (instrD.rType.op == opBne));
    assign branchTarget = pc4D + {immExt[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset || flushExecute) begin
            aluOpE     <= aluAdd;
            aluSrcImmE <= 1'b0;
            regWriteE  <= 1'b0;
            memReadE   <= 1'b0;
            memWriteE  <= 1'b0;
            destE      <= '0;
            srcAE      <= '0;
            srcBE      <= '0;
        end else begin
            aluOpE     <= aluOp;
            aluSrcImmE <= aluSrcImm;
            regWriteE  <= regWrite;
            memReadE   <= memRead;
            memWriteE  <= memWrite;
            destE      <= dest;
            srcAE      <= readAddrA;
            srcBE      <= readAddrB;
        end
    end

    always_ff @(posedge clk) begin
        operandAE <= opA;
        operandBE <= opB;
        immE      <= immExt;
    end

endmodule

`default_nettype wire

//--- hw/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire  [aluOpWidth-1:0]    aluOpE,
    input  wire                      aluSrcImmE,
    input  wire                      regWriteE,
    input  wire                      memReadE,
    input  wire                      memWriteE,
    input  wire  [regAddrWidth-1:0]  destE,
    input  wire  [dataWidth-1:0]     operandAE,
    input  wire  [dataWidth-1:0]     operandBE,
    input  wire  [dataWidth-1:0]     immE,
    input  wire  [fwdWidth-1:0]      fwdSrcAE,
    input  wire  [fwdWidth-1:0]      fwdSrcBE,
    input  wire  [dataWidth-1:0]     writeDataW,
    output logic [dataWidth-1:0]     aluResultM,
    output logic [dataWidth-1:0]     storeDataM,
    output logic                     regWriteM,
    output logic                     memReadM,
    output logic                     memWriteM,
    output logic [regAddrWidth-1:0]  destM
);
    logic [dataWidth-1:0] srcA;
    logic [dataWidth-1:0] regB;
    logic [dataWidth-1:0] srcB;
    logic [dataWidth-1:0] aluResult;

    assign srcA = (fwdSrcAE == fwdMem) ? aluResultM :
                  (fwdSrcAE == fwdWb)  ? writeDataW : operandAE;
    assign regB = (fwdSrcBE == fwdMem) ? aluResultM :
                  (fwdSrcBE == fwdWb)  ? writeDataW : operandBE;
    assign srcB = aluSrcImmE ? immE : regB;

    always_comb begin
        case (aluOpE)
            aluSub:  aluResult = srcA - srcB;
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            aluSlt:  aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
            aluLui:  aluResult = {srcB[15:0], 16'h0000};
            default: aluResult = srcA + srcB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM <= 1'b0;
            memReadM  <= 1'b0;
            memWriteM <= 1'b0;
            destM     <= '0;
        end else begin
            regWriteM <= regWriteE;
            memReadM  <= memReadE;
            memWriteM <= memWriteE;
            destM     <= destE;
        end
    end

    // Store data is the bypassed rt, not the immediate
    always_ff @(posedge clk) begin
        aluResultM <= aluResult;
        storeDataM <= regB;
    end

    storeAligned: assert property (@(posedge clk) disable iff (reset)
        memWriteM |-> aluResultM[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hw/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage
    import isaPkg::*;
#(
    parameter logic [dataWidth-1:0] resetVector = '0
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  stallFetch,
    input  wire                  branchTaken,
    input  wire  [dataWidth-1:0] branchTarget,
    input  wire  [dataWidth-1:0] instr,
    output logic [dataWidth-1:0] instrAddr,
    output instrT                instrD,
    output logic [dataWidth-1:0] pc4D
);
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pc4;
    logic [dataWidth-1:0] nextPc;

    assign pc4       = pc + 32'd4;
    assign instrAddr = pc;

    // The branch in decode redirects past the slot now being fetched
    assign nextPc = branchTaken ? branchTarget : pc4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
        end else if (!stallFetch) begin
            pc <= nextPc;
        end
    end

    // IF/ID, cleared to a nop
    always_ff @(posedge clk) begin
        if (reset) begin
            instrD <= '0;
            pc4D   <= '0;
        end else if (!stallFetch) begin
            instrD <= instr;
            pc4D   <= pc4;
        end
    end

endmodule

`default_nettype wire

//--- hw/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input  wire  [regAddrWidth-1:0] srcAD,
    input  wire  [regAddrWidth-1:0] srcBD,
    input  wire                     isBranchD,
    input  wire  [regAddrWidth-1:0] srcAE,
    input  wire  [regAddrWidth-1:0] srcBE,
    input  wire  [regAddrWidth-1:0] destE,
    input  wire                     memReadE,
    input  wire                     regWriteE,
    input  wire  [regAddrWidth-1:0] destM,
    input  wire                     memReadM,
    input  wire                     regWriteM,
    input  wire  [regAddrWidth-1:0] destW,
    input  wire                     regWriteW,
    output logic                    stallFetch,
    output logic                    flushExecute,
    output logic [fwdWidth-1:0]     fwdSrcAD,
    output logic [fwdWidth-1:0]     fwdSrcBD,
    output logic [fwdWidth-1:0]     fwdSrcAE,
    output logic [fwdWidth-1:0]     fwdSrcBE
);
    logic aluInM;
    logic loadUse;
    logic branchWait;

    // Newest producer wins
    function automatic logic [fwdWidth-1:0] pickFwd(
        input logic [regAddrWidth-1:0] src,
        input logic                    memHit,
        input logic [regAddrWidth-1:0] memDest,
        input logic                    wbHit,
        input logic [regAddrWidth-1:0] wbDest
    );
        if (src == '0) begin
            return fwdNone;
        end
        if (memHit && memDest == src) begin
            return fwdMem;
        end
        if (wbHit && wbDest == src) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    // A load in memory has only its address there
    assign aluInM = regWriteM && !memReadM;

    assign fwdSrcAD = pickFwd(srcAD, aluInM, destM, regWriteW, destW);
    assign fwdSrcBD = pickFwd(srcBD, aluInM, destM, regWriteW, destW);
    assign fwdSrcAE = pickFwd(srcAE, aluInM, destM, regWriteW, destW);
    assign fwdSrcBE = pickFwd(srcBE, aluInM, destM, regWriteW, destW);

    assign loadUse = memReadE && destE != '0 && (destE == srcAD || destE == srcBD);

    // Compare operands must be final in decode
    assign branchWait = isBranchD &&
        ((regWriteE && destE != '0 && (destE == srcAD || destE == srcBD)) ||
         (memReadM && destM != '0 && (destM == srcAD || destM == srcBD)));

    assign stallFetch   = loadUse || branchWait;
    assign flushExecute = stallFetch;

    always_comb begin
        noZeroFwd: assert final (
            !(srcAD == '0 && fwdSrcAD != fwdNone) && !(srcBD == '0 && fwdSrcBD != fwdNone) &&
            !(srcAE == '0 && fwdSrcAE != fwdNone) && !(srcBE == '0 && fwdSrcBE != fwdNone));
    end

endmodule

`default_nettype wire

//--- hw/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    // One instruction word seen through two field layouts
    typedef union packed {
        struct packed {
            logic [5:0]              op;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [4:0]              shamt;
            logic [5:0]              funct;
        } rType;
        struct packed {
            logic [5:0]              op;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [15:0]             imm;
        } iType;
    } instrT;

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // SPECIAL function field
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

endpackage

`default_nettype wire

//--- hw/memWriteback.sv
`timescale 1ns/1ps
`default_nettype none

module memWriteback
    import isaPkg::*;
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire  [dataWidth-1:0]     aluResultM,
    input  wire  [dataWidth-1:0]     storeDataM,
    input  wire                      regWriteM,
    input  wire                      memReadM,
    input  wire                      memWriteM,
    input  wire  [regAddrWidth-1:0]  destM,
    input  wire  [dataWidth-1:0]     prReadData,
    output logic [dataWidth-1:0]     prAddr,
    output logic [dataWidth-1:0]     prWriteData,
    output logic                     prWrite,
    output logic                     regWriteW,
    output logic [regAddrWidth-1:0]  destW,
    output logic [dataWidth-1:0]     writeDataW
);
    logic                 memReadW;
    logic [dataWidth-1:0] aluResultW;
    logic [dataWidth-1:0] readDataW;

    // Bus answers in the same cycle
    assign prAddr      = aluResultM;
    assign prWriteData = storeDataM;
    assign prWrite     = memWriteM;

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteW <= 1'b0;
            memReadW  <= 1'b0;
            destW     <= '0;
        end else begin
            regWriteW <= regWriteM;
            memReadW  <= memReadM;
            destW     <= destM;
        end
    end

    always_ff @(posedge clk) begin
        aluResultW <= aluResultM;
        readDataW  <= prReadData;
    end

    assign writeDataW = memReadW ? readDataW : aluResultW;

endmodule

`default_nettype wire

//--- hw/pipePkg.sv
`default_nettype none

package pipePkg;

    localparam int fwdWidth   = 2;
    localparam int aluOpWidth = 3;

    // Operand bypass sources
    localparam logic [fwdWidth-1:0] fwdNone = 2'd0;
    localparam logic [fwdWidth-1:0] fwdMem  = 2'd1;
    localparam logic [fwdWidth-1:0] fwdWb   = 2'd2;

    localparam logic [aluOpWidth-1:0] aluAdd = 3'd0;
    localparam logic [aluOpWidth-1:0] aluSub = 3'd1;
    localparam logic [aluOpWidth-1:0] aluAnd = 3'd2;
    localparam logic [aluOpWidth-1:0] aluOr  = 3'd3;
    localparam logic [aluOpWidth-1:0] aluSlt = 3'd4;
    localparam logic [aluOpWidth-1:0] aluLui = 3'd5;

endpackage

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
    import isaPkg::*;
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire  [regAddrWidth-1:0] readAddrA,
    input  wire  [regAddrWidth-1:0] readAddrB,
    input  wire                     regWriteW,
    input  wire  [regAddrWidth-1:0] destW,
    input  wire  [dataWidth-1:0]    writeDataW,
    output logic [dataWidth-1:0]    readDataA,
    output logic [dataWidth-1:0]    readDataB
);
    logic [dataWidth-1:0] regs [32];
    logic                 writeEn;

    assign writeEn = regWriteW && (destW != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[destW] <= writeDataW;
        end
    end

    // Write-first, so decode sees the value retiring this cycle
    assign readDataA = (writeEn && destW == readAddrA) ? writeDataW : regs[readAddrA];
    assign readDataB = (writeEn && destW == readAddrB) ? writeDataW : regs[readAddrB];

    zeroRegRead: assert property (@(posedge clk) disable iff (reset)
        readAddrA == '0 |-> readDataA == '0);

endmodule

`default_nettype wire

//--- testbench/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb
    import isaPkg::*;
#(
    parameter int randSeed = 4115
) ();
    localparam logic [31:0] resetVector = 32'h0000_0400;
    localparam int clkPeriod   = 10;
    localparam int resetCycles = 10;
    localparam int progLen     = 200;
    localparam int stopIdx     = progLen - 2;
    localparam int drainCycles = 20;
    localparam int watchdogNs  = progLen * 4 * clkPeriod + resetCycles * clkPeriod;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] instrAddr;
    logic [31:0] prAddr;
    logic [31:0] prWriteData;
    logic        prWrite;
    logic [31:0] prReadData;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    int          seed;
    int          storeIdx;
    int          expCount;
    int          valueErrors;
    int          orderErrors;

    cpu #(
        .resetVector(resetVector)
    ) u_dut (
        .clk(clk),
        .reset(reset),
        .instrAddr(instrAddr),
        .instr(instr),
        .prAddr(prAddr),
        .prWriteData(prWriteData),
        .prWrite(prWrite),
        .prReadData(prReadData)
    );

    isaModel model ();

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        logic [31:0] offset;
        offset = (addr - resetVector) >> 2;
        if (offset < 32'd256) begin
            return imem[offset[7:0]];
        end
        return 32'h0000_0000;
    endfunction

    // Both memories answer within the cycle
    assign instr      = fetchWord(instrAddr);
    assign prReadData = dmem[prAddr[7:2]];

    function automatic int pick(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic buildProgram();
        int         kind;
        int         room;
        logic       prevBranch;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        prevBranch = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < stopIdx; i++) begin
            rs   = 5'(1 + pick(7));
            rt   = 5'(1 + pick(7));
            rd   = 5'(1 + pick(7));
            kind = pick(14);
            // No branch in a delay slot, none just before the closing loop
            if (kind >= 12 && (prevBranch || i > stopIdx - 2)) begin
                kind = pick(12);
            end
            case (kind)
                0:      imem[i] = encodeR(fnAddu, rs, rt, rd);
                1:      imem[i] = encodeR(fnSubu, rs, rt, rd);
                2:      imem[i] = encodeR(fnAnd, rs, rt, rd);
                3:      imem[i] = encodeR(fnOr, rs, rt, rd);
                4:      imem[i] = encodeR(fnSlt, rs, rt, rd);
                5:      imem[i] = encodeI(opAddiu, rs, rt, 16'(pick(65536)));
                6:      imem[i] = encodeI(opOri, rs, rt, 16'(pick(65536)));
                7:      imem[i] = encodeI(opLui, 5'd0, rt, 16'(pick(65536)));
                8, 9:   imem[i] = encodeI(opLw, 5'd0, rt, 16'(pick(64) * 4));
                10, 11: imem[i] = encodeI(opSw, 5'd0, rt, 16'(pick(64) * 4));
                default: begin
                    // Same register on both sides half the time, so beq is taken
                    if (pick(2) == 0) begin
                        rt = rs;
                    end
                    room = (stopIdx - 1 - i < 4) ? stopIdx - 1 - i : 4;
                    imem[i] = encodeI((kind == 12) ? opBeq : opBne, rs, rt,
                                      16'(1 + pick(room)));
                end
            endcase
            prevBranch = (kind >= 12);
        end
        // Closing self-loop with a nop in its slot
        imem[stopIdx]     = encodeI(opBeq, 5'd0, 5'd0, 16'hffff);
        imem[stopIdx + 1] = 32'h0000_0000;
    endtask

    task automatic loadMemories();
        for (int i = 0; i < 256; i++) begin
            model.setInstr(i, imem[i]);
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = (i * 32'h9e37_79b1) ^ 32'h1357_0000;
            model.setWord(i, dmem[i]);
        end
    endtask

    task automatic checkResetState();
        assert (instrAddr == resetVector) else begin
            valueErrors++;
            $display("ERR %0t instrAddr expected %h actual %h", $time, resetVector, instrAddr);
        end
        for (int c = 0; c < 3; c++) begin
            assert (prWrite == 1'b0) else begin
                valueErrors++;
                $display("ERR %0t prWrite expected 0 actual %b", $time, prWrite);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic checkStore();
        logic [31:0] expA;
        logic [31:0] expD;
        assert (storeIdx < expCount) else begin
            orderErrors++;
            $display("At %0t ns the CPU made a store beyond the %0d expected", $time, expCount);
        end
        if (storeIdx < expCount) begin
            expA = model.expAddr[storeIdx];
            expD = model.expData[storeIdx];
            assert (prAddr == expA) else begin
                valueErrors++;
                $display("ERR %0t prAddr expected %h actual %h", $time, expA, prAddr);
            end
            assert (prWriteData == expD) else begin
                valueErrors++;
                $display("ERR %0t prWriteData expected %h actual %h", $time, expD, prWriteData);
            end
        end
        storeIdx++;
    endtask

    always @(posedge clk) begin
        if (!reset && prWrite) begin
            checkStore();
            dmem[prAddr[7:2]] <= prWriteData;
        end
    end

    initial begin
        seed        = randSeed;
        reset       = 1'b1;
        storeIdx    = 0;
        valueErrors = 0;
        orderErrors = 0;
        buildProgram();
        loadMemories();
        model.run(stopIdx);
        expCount = model.storeCount;
        repeat (resetCycles) @(posedge clk);
        #1;
        reset = 1'b0;
        checkResetState();
        while (storeIdx < expCount) begin
            @(posedge clk);
        end
        // Extra stores after the last one count as errors
        repeat (drainCycles) @(posedge clk);
        #1;
        $display("Errors: %0d value, %0d sequence, %0d of %0d stores seen",
                 valueErrors, orderErrors, storeIdx, expCount);
        if (valueErrors == 0 && orderErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("Timeout at %0t ns, the program did not finish", $time);
        $display("Errors: %0d value, %0d sequence, %0d of %0d stores seen",
                 valueErrors, orderErrors, storeIdx, expCount);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/isaModel.sv
`timescale 1ns/1ps
`default_nettype none

module isaModel
    import isaPkg::*;
();
    localparam int progWords = 256;
    localparam int maxStores = 256;

    logic [31:0] prog [progWords];
    logic [31:0] mem [64];
    logic [31:0] regs [32];
    logic [31:0] expAddr [maxStores];
    logic [31:0] expData [maxStores];
    int          storeCount;

    task automatic setInstr(input int idx, input logic [31:0] word);
        prog[idx] = word;
    endtask

    task automatic setWord(input int idx, input logic [31:0] word);
        mem[idx] = word;
    endtask

    // Executes with one delay slot per branch until fetch reaches stopIdx
    task automatic run(input int stopIdx);
        instrT       ir;
        int          idx;
        int          nextIdx;
        int          newNext;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immS;
        logic [31:0] addr;
        logic [31:0] result;
        logic        write;
        logic [4:0]  dest;
        storeCount = 0;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        idx     = 0;
        nextIdx = 1;
        while (idx != stopIdx) begin
            ir      = prog[idx];
            a       = regs[ir.rType.rs];
            b       = regs[ir.rType.rt];
            immS    = {{16{ir.iType.imm[15]}}, ir.iType.imm};
            addr    = a + immS;
            newNext = nextIdx + 1;
            write   = 1'b1;
            dest    = ir.iType.rt;
            result  = '0;
            case (ir.rType.op)
                opSpecial: begin
                    dest = ir.rType.rd;
                    case (ir.rType.funct)
                        fnAddu:  result = a + b;
                        fnSubu:  result = a - b;
                        fnAnd:   result = a & b;
                        fnOr:    result = a | b;
                        fnSlt:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: write = 1'b0;
                    endcase
                end
                opAddiu: result = a + immS;
                opOri:   result = a | {16'h0000, ir.iType.imm};
                opLui:   result = {ir.iType.imm, 16'h0000};
                opLw:    result = mem[addr[7:2]];
                opSw: begin
                    write               = 1'b0;
                    mem[addr[7:2]]      = b;
                    expAddr[storeCount] = addr;
                    expData[storeCount] = b;
                    storeCount++;
                end
                opBeq, opBne: begin
                    write = 1'b0;
                    if ((a == b) == (ir.rType.op == opBeq)) begin
                        newNext = idx + 1 + int'($signed(immS));
                    end
                end
                default: write = 1'b0;
            endcase
            if (write && dest != 5'd0) begin
                regs[dest] = result;
            end
            idx     = nextIdx;
            nextIdx = newNext;
        end
    endtask

endmodule

`default_nettype wire
